// File: Bender.yml
package:
  name: decodeStage

sources:
  - hw/rvDecodePkg.sv
  - hw/decodeCtrlIf.sv
  - hw/mainDecode.sv
  - hw/aluDecode.sv
  - hw/immExtend.sv
  - hw/decodeStage.sv
  - target: test
    files:
      - verification/decodeStageTb.sv

// File: decodeStage.f
hw/rvDecodePkg.sv
hw/decodeCtrlIf.sv
hw/mainDecode.sv
hw/aluDecode.sv
hw/immExtend.sv
hw/decodeStage.sv
verification/decodeStageTb.sv

// File: hw/aluDecode.sv
// ALU operation decoder from ALU class, funct3, funct7 bit 5 and opcode bit 5
`timescale 1ns/1ps

module aluDecode (
    decodeCtrlIf.aluSide                    ctrl,
    input  logic [rvDecodePkg::funct3W-1:0] funct3,
    input  logic                            funct7b5,
    input  logic                            opcodeb5,  // Set for OP, clear for OP-IMM
    output rvDecodePkg::aluOpT              aluOp
);

    logic rTypeSub;

    // ADDI has no SUB form even when imm[10] is set
    assign rTypeSub = opcodeb5 & funct7b5;

    always_comb begin
        aluOp = rvDecodePkg::aluOpAdd;
        case (ctrl.aluClass)
            rvDecodePkg::aluAdd: begin
                aluOp = rvDecodePkg::aluOpAdd;
            end
            rvDecodePkg::aluBranch: begin
                aluOp = rvDecodePkg::aluOpSub;
            end
            rvDecodePkg::aluPassB: begin
                aluOp = rvDecodePkg::aluOpPassB;
            end
            rvDecodePkg::aluFunct: begin
                case (funct3)
                    3'b000:  aluOp = rTypeSub ? rvDecodePkg::aluOpSub : rvDecodePkg::aluOpAdd;
                    3'b001:  aluOp = rvDecodePkg::aluOpSll;
                    3'b010:  aluOp = rvDecodePkg::aluOpSlt;
                    3'b011:  aluOp = rvDecodePkg::aluOpSltu;
                    3'b100:  aluOp = rvDecodePkg::aluOpXor;
                    3'b101:  aluOp = funct7b5 ? rvDecodePkg::aluOpSra : rvDecodePkg::aluOpSrl;
                    3'b110:  aluOp = rvDecodePkg::aluOpOr;
                    default: aluOp = rvDecodePkg::aluOpAnd;
                endcase
            end
            default: begin
                aluOp = rvDecodePkg::aluOpAdd;
            end
        endcase
    end

endmodule

// File: hw/decodeCtrlIf.sv
// Control bundle from the main decoder with decoder, aluSide and sink modports
`timescale 1ns/1ps

interface decodeCtrlIf;

    logic                   regWrite;
    logic                   memWrite;
    logic                   branch;
    logic                   jump;
    rvDecodePkg::resultSrcT resultSrc;
    logic                   aluSrcA;   // PC instead of rs1
    logic                   aluSrcB;   // Imm instead of rs2
    rvDecodePkg::aluClassT  aluClass;
    rvDecodePkg::immSrcT    immSrc;
    rvDecodePkg::memWidthT  memWidth;
    logic                   loadUnsigned;
    logic                   illegal;

    modport decoder (
        output regWrite, memWrite, branch, jump, resultSrc, aluSrcA, aluSrcB,
        output aluClass, immSrc, memWidth, loadUnsigned, illegal
    );

    modport aluSide (
        input aluClass
    );

    modport sink (
        input regWrite, memWrite, branch, jump, resultSrc, aluSrcA, aluSrcB,
        input immSrc, memWidth, loadUnsigned, illegal
    );

endinterface

// File: hw/decodeStage.sv
// RV32I decode stage top with field split, decoders and the ID/EX pipeline register
`timescale 1ns/1ps

module decodeStage (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              instrValid,
    input  logic [31:0]                       instr,
    output logic                              exValid,
    output logic                              exIllegal,
    output logic                              exRegWrite,
    output logic                              exMemWrite,
    output logic                              exBranch,
    output logic                              exJump,
    output rvDecodePkg::resultSrcT            exResultSrc,
    output logic                              exAluSrcA,
    output logic                              exAluSrcB,
    output rvDecodePkg::aluOpT                exAluOp,
    output rvDecodePkg::memWidthT             exMemWidth,
    output logic                              exLoadUnsigned,
    output logic [rvDecodePkg::xlen-1:0]      exImm,
    output logic [rvDecodePkg::regAddrW-1:0]  exRs1,
    output logic [rvDecodePkg::regAddrW-1:0]  exRs2,
    output logic [rvDecodePkg::regAddrW-1:0]  exRd
);

    logic [rvDecodePkg::opcodeW-1:0]  opcode;
    logic [rvDecodePkg::funct3W-1:0]  funct3;
    logic                             funct7b5;
    logic [rvDecodePkg::regAddrW-1:0] rs1;
    logic [rvDecodePkg::regAddrW-1:0] rs2;
    logic [rvDecodePkg::regAddrW-1:0] rd;
    rvDecodePkg::aluOpT               aluOp;
    logic [rvDecodePkg::xlen-1:0]     imm;

    assign opcode   = instr[6:0];
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign funct7b5 = instr[30];

    decodeCtrlIf ctrlBus ();

    mainDecode uMainDecode (
        .opcode (opcode),
        .funct3 (funct3),
        .ctrl   (ctrlBus.decoder)
    );

    aluDecode uAluDecode (
        .ctrl     (ctrlBus.aluSide),
        .funct3   (funct3),
        .funct7b5 (funct7b5),
        .opcodeb5 (opcode[5]),
        .aluOp    (aluOp)
    );

    immExtend uImmExtend (
        .instrHi (instr[31:7]),
        .immSrc  (ctrlBus.sink.immSrc),
        .imm     (imm)
    );

    // Control half of ID/EX, a bubble when no instruction arrives
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exValid    <= 1'b0;
            exIllegal  <= 1'b0;
            exRegWrite <= 1'b0;
            exMemWrite <= 1'b0;
            exBranch   <= 1'b0;
            exJump     <= 1'b0;
        end else begin
            exValid    <= instrValid;
            exIllegal  <= instrValid & ctrlBus.sink.illegal;
            exRegWrite <= instrValid & ctrlBus.sink.regWrite;
            exMemWrite <= instrValid & ctrlBus.sink.memWrite;
            exBranch   <= instrValid & ctrlBus.sink.branch;
            exJump     <= instrValid & ctrlBus.sink.jump;
        end
    end

    // Payload half, holds across idle cycles
    always_ff @(posedge clk) begin
        if (instrValid) begin
            exResultSrc    <= ctrlBus.sink.resultSrc;
            exAluSrcA      <= ctrlBus.sink.aluSrcA;
            exAluSrcB      <= ctrlBus.sink.aluSrcB;
            exAluOp        <= aluOp;
            exMemWidth     <= ctrlBus.sink.memWidth;
            exLoadUnsigned <= ctrlBus.sink.loadUnsigned;
            exImm          <= imm;
            exRs1          <= rs1;
            exRs2          <= rs2;
            exRd           <= rd;
        end
    end

endmodule

// File: hw/immExtend.sv
// Immediate reassembly and sign extension for I, S, B, J and U formats
`timescale 1ns/1ps

module immExtend (
    input  logic [31:7]                  instrHi,  // Keeps ISA bit numbering
    input  rvDecodePkg::immSrcT          immSrc,
    output logic [rvDecodePkg::xlen-1:0] imm
);

    logic signBit;

    assign signBit = instrHi[31];

    always_comb begin
        case (immSrc)
            rvDecodePkg::immI: begin
                imm = {{20{signBit}}, instrHi[31:20]};
            end
            rvDecodePkg::immS: begin
                imm = {{20{signBit}}, instrHi[31:25], instrHi[11:7]};
            end
            rvDecodePkg::immB: begin
                imm = {{19{signBit}}, signBit, instrHi[7], instrHi[30:25],
                       instrHi[11:8], 1'b0};
            end
            rvDecodePkg::immJ: begin
                imm = {{11{signBit}}, signBit, instrHi[19:12], instrHi[20],
                       instrHi[30:21], 1'b0};
            end
            rvDecodePkg::immU: begin
                imm = {instrHi[31:12], 12'b0};
            end
            default: begin
                imm = '0;  // Unused encodings
            end
        endcase
    end

endmodule

// File: hw/mainDecode.sv
// Main opcode decoder with load/store width handling and illegal opcode detection
`timescale 1ns/1ps

module mainDecode (
    input  logic [rvDecodePkg::opcodeW-1:0] opcode,
    input  logic [rvDecodePkg::funct3W-1:0] funct3,
    decodeCtrlIf.decoder                    ctrl
);

    logic illegalOp;

    always_comb begin
        illegalOp         = 1'b0;
        ctrl.regWrite     = 1'b0;
        ctrl.memWrite     = 1'b0;
        ctrl.branch       = 1'b0;
        ctrl.jump         = 1'b0;
        ctrl.resultSrc    = rvDecodePkg::resAlu;
        ctrl.aluSrcA      = 1'b0;
        ctrl.aluSrcB      = 1'b0;
        ctrl.aluClass     = rvDecodePkg::aluAdd;
        ctrl.immSrc       = rvDecodePkg::immI;
        ctrl.memWidth     = rvDecodePkg::memWord;
        ctrl.loadUnsigned = 1'b0;

        case (rvDecodePkg::opcodeT'(opcode))
            rvDecodePkg::opOp: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluClass = rvDecodePkg::aluFunct;
            end
            rvDecodePkg::opImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcB  = 1'b1;
                ctrl.aluClass = rvDecodePkg::aluFunct;
            end
            rvDecodePkg::opLoad: begin
                ctrl.regWrite     = 1'b1;
                ctrl.resultSrc    = rvDecodePkg::resMem;
                ctrl.aluSrcB      = 1'b1;
                ctrl.loadUnsigned = funct3[2];
                if (funct3[1:0] == 2'b11 || funct3 == 3'b110) begin
                    illegalOp = 1'b1;  // LWU and 64-bit loads
                end else begin
                    ctrl.memWidth = rvDecodePkg::memWidthT'(funct3[1:0]);
                end
            end
            rvDecodePkg::opStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcB  = 1'b1;
                ctrl.immSrc   = rvDecodePkg::immS;
                if (funct3[1:0] == 2'b11) begin
                    illegalOp = 1'b1;
                end else begin
                    ctrl.memWidth = rvDecodePkg::memWidthT'(funct3[1:0]);
                end
            end
            rvDecodePkg::opBranch: begin
                ctrl.branch   = 1'b1;
                ctrl.immSrc   = rvDecodePkg::immB;
                ctrl.aluClass = rvDecodePkg::aluBranch;
            end
            rvDecodePkg::opJal: begin
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.resultSrc = rvDecodePkg::resPcPlus4;
                ctrl.immSrc    = rvDecodePkg::immJ;
            end
            rvDecodePkg::opJalr: begin
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.resultSrc = rvDecodePkg::resPcPlus4;
                ctrl.aluSrcB   = 1'b1;  // Target is rs1 + imm
            end
            rvDecodePkg::opLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcB  = 1'b1;
                ctrl.immSrc   = rvDecodePkg::immU;
                ctrl.aluClass = rvDecodePkg::aluPassB;
            end
            rvDecodePkg::opAuipc: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcA  = 1'b1;
                ctrl.aluSrcB  = 1'b1;
                ctrl.immSrc   = rvDecodePkg::immU;
            end
            default: begin
                illegalOp = 1'b1;  // FENCE, SYSTEM and unknown
            end
        endcase

        // Nothing may write state on an illegal instruction
        if (illegalOp) begin
            ctrl.regWrite = 1'b0;
            ctrl.memWrite = 1'b0;
            ctrl.branch   = 1'b0;
            ctrl.jump     = 1'b0;
        end
        ctrl.illegal = illegalOp;
    end

endmodule

// File: hw/rvDecodePkg.sv
// RV32I decode enums (opcode, ALU class and op, immediate format, result, width) and field widths
package rvDecodePkg;

    localparam int xlen     = 32;
    localparam int opcodeW  = 7;
    localparam int funct3W  = 3;
    localparam int regAddrW = 5;

    // RV32I major opcodes handled by the stage
    typedef enum logic [opcodeW-1:0] {
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opAuipc  = 7'b0010111,
        opStore  = 7'b0100011,
        opOp     = 7'b0110011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111
    } opcodeT;

    // Coarse ALU request from the main decoder
    typedef enum logic [1:0] {
        aluAdd    = 2'b00,  // Address calc
        aluBranch = 2'b01,  // Compare via subtract
        aluFunct  = 2'b10,  // Look at funct3/funct7
        aluPassB  = 2'b11   // LUI
    } aluClassT;

    typedef enum logic [3:0] {
        aluOpAdd   = 4'd0,
        aluOpSub   = 4'd1,
        aluOpSll   = 4'd2,
        aluOpSlt   = 4'd3,
        aluOpSltu  = 4'd4,
        aluOpXor   = 4'd5,
        aluOpSrl   = 4'd6,
        aluOpSra   = 4'd7,
        aluOpOr    = 4'd8,
        aluOpAnd   = 4'd9,
        aluOpPassB = 4'd10
    } aluOpT;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immJ = 3'b011,
        immU = 3'b100
    } immSrcT;

    // Writeback source select
    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resMem     = 2'b01,
        resPcPlus4 = 2'b10
    } resultSrcT;

    // Same encoding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        memByte = 2'b00,
        memHalf = 2'b01,
        memWord = 2'b10
    } memWidthT;

endpackage

// File: verification/decodeStageTb.sv
// Testbench for the decode stage with file-driven vectors, compare tasks and watchdog
`timescale 1ns/1ps

module decodeStageTb;

    localparam int clkPeriod    = 4;
    localparam int resetCycles  = 16;
    localparam int maxVecs      = 64;
    localparam int fieldsPerVec = 10;

    typedef struct packed {
        logic                   valid;
        logic [31:0]            instr;
        logic                   illegal;
        logic [3:0]             enables;  // regWrite, memWrite, branch, jump
        rvDecodePkg::resultSrcT resultSrc;
        logic                   aluSrcA;
        logic                   aluSrcB;
        rvDecodePkg::aluOpT     aluOp;
        rvDecodePkg::memWidthT  memWidth;
        logic                   loadUnsigned;
        logic [31:0]            imm;
    } vecT;

    logic                   clk;
    logic                   rstN;
    logic                   instrValid;
    logic [31:0]            instr;
    logic                   exValid;
    logic                   exIllegal;
    logic                   exRegWrite;
    logic                   exMemWrite;
    logic                   exBranch;
    logic                   exJump;
    rvDecodePkg::resultSrcT exResultSrc;
    logic                   exAluSrcA;
    logic                   exAluSrcB;
    rvDecodePkg::aluOpT     exAluOp;
    rvDecodePkg::memWidthT  exMemWidth;
    logic                   exLoadUnsigned;
    logic [31:0]            exImm;
    logic [4:0]             exRs1;
    logic [4:0]             exRs2;
    logic [4:0]             exRd;

    logic [31:0] rawMem [0:maxVecs*fieldsPerVec-1];
    vecT         vecs [0:maxVecs-1];
    vecT         lastValid;
    logic        haveLast;
    logic        stimLoaded;
    int          nVec;
    int          errors;
    int          checks;
    int          idx;

    decodeStage dut (
        .clk            (clk),
        .rstN           (rstN),
        .instrValid     (instrValid),
        .instr          (instr),
        .exValid        (exValid),
        .exIllegal      (exIllegal),
        .exRegWrite     (exRegWrite),
        .exMemWrite     (exMemWrite),
        .exBranch       (exBranch),
        .exJump         (exJump),
        .exResultSrc    (exResultSrc),
        .exAluSrcA      (exAluSrcA),
        .exAluSrcB      (exAluSrcB),
        .exAluOp        (exAluOp),
        .exMemWidth     (exMemWidth),
        .exLoadUnsigned (exLoadUnsigned),
        .exImm          (exImm),
        .exRs1          (exRs1),
        .exRs2          (exRs2),
        .exRd           (exRd)
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    task automatic checkBit(input string name, input string field, input logic exp,
                            input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s %s: expected %0b, actual %0b", name, field, exp, act);
        end
    endtask

    task automatic checkAluOp(input string name, input rvDecodePkg::aluOpT exp,
                              input rvDecodePkg::aluOpT act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s exAluOp: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic checkResultSrc(input string name, input rvDecodePkg::resultSrcT exp,
                                  input rvDecodePkg::resultSrcT act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s exResultSrc: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic checkWidth(input string name, input rvDecodePkg::memWidthT exp,
                              input rvDecodePkg::memWidthT act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s exMemWidth: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic checkWord(input string name, input string field, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s %s: expected %08h, actual %08h", name, field, exp, act);
        end
    endtask

    // Valid, illegal flag and the four enables
    task automatic checkControl(input string name, input logic valid, input logic illegal,
                                input logic [3:0] enables);
        checkBit(name, "exValid", valid, exValid);
        checkBit(name, "exIllegal", illegal, exIllegal);
        checkBit(name, "exRegWrite", enables[3], exRegWrite);
        checkBit(name, "exMemWrite", enables[2], exMemWrite);
        checkBit(name, "exBranch", enables[1], exBranch);
        checkBit(name, "exJump", enables[0], exJump);
    endtask

    task automatic checkPayload(input string name, input vecT v);
        checkResultSrc(name, v.resultSrc, exResultSrc);
        checkBit(name, "exAluSrcA", v.aluSrcA, exAluSrcA);
        checkBit(name, "exAluSrcB", v.aluSrcB, exAluSrcB);
        checkAluOp(name, v.aluOp, exAluOp);
        checkWidth(name, v.memWidth, exMemWidth);
        checkBit(name, "exLoadUnsigned", v.loadUnsigned, exLoadUnsigned);
        checkWord(name, "exImm", v.imm, exImm);
        // Register fields sit at fixed ISA positions
        checkWord(name, "exRs1", {27'b0, v.instr[19:15]}, {27'b0, exRs1});
        checkWord(name, "exRs2", {27'b0, v.instr[24:20]}, {27'b0, exRs2});
        checkWord(name, "exRd", {27'b0, v.instr[11:7]}, {27'b0, exRd});
    endtask

    task automatic checkVector(input int i);
        vecT   v;
        string name;
        v    = vecs[i];
        name = $sformatf("vec%0d_%08h", i, v.instr);
        if (v.valid) begin
            checkControl(name, 1'b1, v.illegal, v.enables);
            checkPayload(name, v);
            lastValid = v;
            haveLast  = 1'b1;
        end else begin
            checkControl(name, 1'b0, 1'b0, 4'b0000);
            if (haveLast) begin
                checkPayload(name, lastValid);  // Idle cycle keeps the data fields
            end
        end
    endtask

    task automatic loadVectors();
        int b;
        // Words past the end of the file keep this marker
        for (int i = 0; i < maxVecs * fieldsPerVec; i++) begin
            rawMem[i] = 32'hbad0_0000 | i;
        end
        $readmemh("verification/decodeStim.txt", rawMem);
        nVec = 0;
        while (nVec < maxVecs && rawMem[nVec*fieldsPerVec] inside {32'h0, 32'h1}) begin
            b = nVec * fieldsPerVec;
            vecs[nVec].valid        = rawMem[b][0];
            vecs[nVec].instr        = rawMem[b+1];
            vecs[nVec].illegal      = rawMem[b+2][0];
            vecs[nVec].enables      = rawMem[b+3][3:0];
            vecs[nVec].resultSrc    = rvDecodePkg::resultSrcT'(rawMem[b+4][1:0]);
            vecs[nVec].aluSrcA      = rawMem[b+5][1];
            vecs[nVec].aluSrcB      = rawMem[b+5][0];
            vecs[nVec].aluOp        = rvDecodePkg::aluOpT'(rawMem[b+6][3:0]);
            vecs[nVec].memWidth     = rvDecodePkg::memWidthT'(rawMem[b+7][1:0]);
            vecs[nVec].loadUnsigned = rawMem[b+8][0];
            vecs[nVec].imm          = rawMem[b+9];
            nVec++;
        end
    endtask

    initial begin
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = 32'h0;
        errors     = 0;
        checks     = 0;
        haveLast   = 1'b0;
        stimLoaded = 1'b0;
        loadVectors();
        stimLoaded = 1'b1;
        if (nVec == 0) begin
            errors++;
            $display("No stimulus records could be read from verification/decodeStim.txt");
        end

        repeat (resetCycles) begin
            @(negedge clk);
            checkControl("reset", 1'b0, 1'b0, 4'b0000);
        end
        rstN = 1'b1;
        @(negedge clk);
        checkControl("afterReset", 1'b0, 1'b0, 4'b0000);

        // Each vector is checked at the falling edge after its capture edge
        for (idx = 0; idx < nVec; idx++) begin
            instrValid = vecs[idx].valid;
            instr      = vecs[idx].instr;
            @(negedge clk);
            checkVector(idx);
        end
        instrValid = 1'b0;

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        wait (stimLoaded);
        #((resetCycles + nVec + 10) * clkPeriod);
        $display("Timeout: the run did not finish within %0d clock cycles",
                 resetCycles + nVec + 10);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: verification/decodeStim.txt
// valid instr illegal enables(regWrite,memWrite,branch,jump) resultSrc srcAB(A,B)
// aluOp memWidth loadUnsigned imm ; idle rows (valid 0) only use the first two columns
// R-type and I-type ALU ops
1 00C58533 0 8 0 0 0 2 0 0000000C
1 407302B3 0 8 0 0 1 2 0 00000407
1 003150B3 0 8 0 0 6 2 0 00000003
1 403150B3 0 8 0 0 7 2 0 00000403
1 40010093 0 8 0 1 0 2 0 00000400
1 FFF00193 0 8 0 1 0 2 0 FFFFFFFF
1 4032D213 0 8 0 1 7 2 0 00000403
1 0F03F313 0 8 0 1 9 2 0 000000F0
0 FFFFFFFF 0 0 0 0 0 0 0 00000000
// Loads and stores
1 FFC50283 0 8 1 1 0 0 0 FFFFFFFC
1 0025D303 0 8 1 1 0 1 1 00000002
1 7FF12383 0 8 1 1 0 2 0 000007FF
1 005500A3 0 4 0 1 0 0 0 00000001
1 FE659F23 0 4 0 1 0 1 0 FFFFFFFE
1 7E712E23 0 4 0 1 0 2 0 000007FC
0 00C58533 0 0 0 0 0 0 0 00000000
0 00C58533 0 0 0 0 0 0 0 00000000
// Control flow and upper immediates
1 FE208CE3 0 2 0 0 1 2 0 FFFFFFF8
1 FFDFF0EF 0 9 2 0 0 2 0 FFFFFFFC
1 008280E7 0 9 2 1 0 2 0 00000008
1 123452B7 0 8 0 1 A 2 0 12345000
1 FFFFF317 0 8 0 3 0 2 0 FFFFF000
// Illegal opcode and reserved widths
1 0000000F 1 0 0 0 0 2 0 00000000
1 00053283 1 0 1 1 0 2 0 00000000
1 00056283 1 0 1 1 0 2 1 00000000
1 00553023 1 0 0 1 0 2 0 00000000
0 FFFFFFFF 0 0 0 0 0 0 0 00000000
1 00C58533 0 8 0 0 0 2 0 0000000C
